// File: hw/udp_csum_pkg.sv
package udp_csum_pkg;

    // accumulator lanes, any power of two from 1 to 8
    localparam int NUM_LANES = 4;

    // a single lane still needs a one bit index
    localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // ones-complement checksum word
    localparam int WORD_W = 16;

    // protocol number carried in the pseudo-header
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    // udp header length, added to the payload byte count
    localparam int UDP_HDR_BYTES = 8;

    // packer sequencing
    typedef enum logic [1:0] {
        PK_IDLE,
        PK_PAYLOAD,
        PK_FLUSH,
        PK_WAIT
    } packer_state_t;

    // fold sequencing
    typedef enum logic [1:0] {
        FD_IDLE,
        FD_MERGE,
        FD_WRAP,
        FD_OUT
    } fold_state_t;

endpackage

// File: hw/csum_word_packer.sv
`timescale 1ns/1ps

module csum_word_packer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hdr_valid,
    output logic                                  hdr_ready,
    input  logic [31:0]                           src_ip,
    input  logic [31:0]                           dst_ip,
    input  logic [15:0]                           src_port,
    input  logic [15:0]                           dst_port,
    input  logic [7:0]                            payload_data,
    input  logic                                  payload_valid,
    input  logic                                  payload_last,
    output logic                                  payload_ready,
    input  logic                                  fold_idle,
    output logic                                  lane_clear,
    output logic [udp_csum_pkg::WORD_W-1:0]       word,
    output logic [udp_csum_pkg::NUM_LANES-1:0]    word_strobe,
    output logic                                  flush,
    output logic [udp_csum_pkg::WORD_W-1:0]       pseudo_sum,
    output logic [15:0]                           udp_length,
    output logic                                  busy
);

    import udp_csum_pkg::*;

    packer_state_t          state;
    logic                   have_hi;
    logic [7:0]             hi_byte;
    logic [LANE_IDX_W-1:0]  lane_idx;
    logic [15:0]            byte_count;
    logic                   hdr_take;
    logic                   byte_take;
    logic                   word_done;
    logic                   wait_done;
    logic [18:0]            hdr_total;
    logic [16:0]            hdr_fold;

    assign hdr_ready     = (state == PK_IDLE) && fold_idle;
    assign payload_ready = (state == PK_PAYLOAD);
    assign hdr_take      = hdr_valid && hdr_ready;
    assign byte_take     = payload_valid && payload_ready;

    // a word is complete on the low byte, or on a lone last high byte
    assign word_done = byte_take && (have_hi || payload_last);

    // flush must have reached the fold before its idle level means anything
    assign wait_done = (state == PK_WAIT) && fold_idle && !flush;
    assign busy      = (state != PK_IDLE) && !wait_done;

    // ip halves, ports and protocol, folded with end-around carry
    assign hdr_total = src_ip[31:16] + src_ip[15:0] + dst_ip[31:16] + dst_ip[15:0]
                     + src_port + dst_port + IP_PROTO_UDP;
    assign hdr_fold  = hdr_total[15:0] + hdr_total[18:16];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= PK_IDLE;
            have_hi     <= 1'b0;
            lane_idx    <= '0;
            byte_count  <= '0;
            word_strobe <= '0;
            lane_clear  <= 1'b0;
            flush       <= 1'b0;
        end else begin
            word_strobe <= '0;
            lane_clear  <= 1'b0;
            flush       <= 1'b0;
            case (state)
                PK_IDLE: begin
                    if (hdr_take) begin
                        lane_clear <= 1'b1;
                        have_hi    <= 1'b0;
                        lane_idx   <= '0;
                        byte_count <= '0;
                        state      <= PK_PAYLOAD;
                    end
                end
                PK_PAYLOAD: begin
                    if (byte_take) begin
                        byte_count <= byte_count + 16'd1;
                        have_hi    <= !have_hi && !payload_last;
                        if (payload_last) begin
                            state <= PK_FLUSH;
                        end
                    end
                    if (word_done) begin
                        word_strobe <= NUM_LANES'(1) << lane_idx;
                        if (lane_idx == LANE_IDX_W'(NUM_LANES - 1)) begin
                            lane_idx <= '0;
                        end else begin
                            lane_idx <= lane_idx + 1'b1;
                        end
                    end
                end
                PK_FLUSH: begin
                    flush <= 1'b1;
                    state <= PK_WAIT;
                end
                PK_WAIT: begin
                    if (wait_done) begin
                        state <= PK_IDLE;
                    end
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            pseudo_sum <= hdr_fold[15:0] + hdr_fold[16];
        end
        if (byte_take && !have_hi) begin
            hi_byte <= payload_data;
        end
        if (word_done) begin
            // odd last byte is padded with a zero low byte
            word <= have_hi ? {hi_byte, payload_data} : {payload_data, 8'h00};
        end
        if (byte_take && payload_last) begin
            udp_length <= byte_count + 16'd1 + 16'(UDP_HDR_BYTES);
        end
    end

endmodule

// File: hw/csum_lane.sv
`timescale 1ns/1ps

module csum_lane (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  logic                              strobe,
    input  logic [udp_csum_pkg::WORD_W-1:0]   word,
    output logic [udp_csum_pkg::WORD_W-1:0]   lane_sum
);

    import udp_csum_pkg::*;

    logic [WORD_W:0] raw_sum;

    // carry out of bit 15 wraps back into bit 0
    assign raw_sum = {1'b0, lane_sum} + {1'b0, word};

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_sum <= '0;
        end else if (clear) begin
            lane_sum <= '0;
        end else if (strobe) begin
            // a second carry cannot occur after one wrap
            lane_sum <= raw_sum[WORD_W-1:0] + raw_sum[WORD_W];
        end
    end

endmodule

// File: hw/csum_fold.sv
`timescale 1ns/1ps

module csum_fold (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [udp_csum_pkg::NUM_LANES*udp_csum_pkg::WORD_W-1:0] lane_sums,
    input  logic                                                 flush,
    input  logic [udp_csum_pkg::WORD_W-1:0]                      pseudo_sum,
    input  logic [15:0]                                          udp_length,
    output logic [udp_csum_pkg::WORD_W-1:0]                      csum,
    output logic [15:0]                                          csum_length,
    output logic                                                 csum_valid,
    input  logic                                                 csum_ready,
    output logic                                                 fold_idle
);

    import udp_csum_pkg::*;

    fold_state_t            state;
    logic [LANE_IDX_W-1:0]  lane_cnt;
    logic [WORD_W-1:0]      acc;
    logic [WORD_W-1:0]      lane_sel;
    logic [WORD_W:0]        merge_sum;
    logic [WORD_W+1:0]      wrap_total;
    logic [WORD_W:0]        wrap_fold;
    logic [WORD_W-1:0]      result;

    assign fold_idle = (state == FD_IDLE);

    assign lane_sel  = lane_sums[lane_cnt*WORD_W +: WORD_W];
    assign merge_sum = {1'b0, acc} + {1'b0, lane_sel};

    // length counts twice, once in the pseudo-header and once in the udp header
    assign wrap_total = acc + pseudo_sum + udp_length + udp_length;
    assign wrap_fold  = wrap_total[WORD_W-1:0] + wrap_total[WORD_W+1:WORD_W];

    // zero is never sent, it goes out as all ones
    assign result = (~acc == '0) ? '1 : ~acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FD_IDLE;
            lane_cnt   <= '0;
            csum_valid <= 1'b0;
        end else begin
            case (state)
                FD_IDLE: begin
                    if (flush) begin
                        lane_cnt <= '0;
                        state    <= FD_MERGE;
                    end
                end
                FD_MERGE: begin
                    if (lane_cnt == LANE_IDX_W'(NUM_LANES - 1)) begin
                        lane_cnt <= '0;
                        state    <= FD_WRAP;
                    end else begin
                        lane_cnt <= lane_cnt + 1'b1;
                    end
                end
                FD_WRAP: begin
                    state <= FD_OUT;
                end
                FD_OUT: begin
                    // first cycle loads the result, then hold for the consumer
                    if (!csum_valid) begin
                        csum_valid <= 1'b1;
                    end else if (csum_ready) begin
                        csum_valid <= 1'b0;
                        state      <= FD_IDLE;
                    end
                end
                default: state <= FD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            FD_IDLE: begin
                acc <= '0;
            end
            FD_MERGE: begin
                acc <= merge_sum[WORD_W-1:0] + merge_sum[WORD_W];
            end
            FD_WRAP: begin
                acc <= wrap_fold[WORD_W-1:0] + wrap_fold[WORD_W];
            end
            FD_OUT: begin
                if (!csum_valid) begin
                    csum        <= result;
                    csum_length <= udp_length;
                end
            end
            default: acc <= '0;
        endcase
    end

endmodule

// File: hw/udp_csum_gen.sv
`timescale 1ns/1ps

module udp_csum_gen (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              hdr_valid,
    output logic                              hdr_ready,
    input  logic [31:0]                       src_ip,
    input  logic [31:0]                       dst_ip,
    input  logic [15:0]                       src_port,
    input  logic [15:0]                       dst_port,
    input  logic [7:0]                        payload_data,
    input  logic                              payload_valid,
    input  logic                              payload_last,
    output logic                              payload_ready,
    output logic [udp_csum_pkg::WORD_W-1:0]   csum,
    output logic [15:0]                       csum_length,
    output logic                              csum_valid,
    input  logic                              csum_ready,
    output logic                              busy
);

    import udp_csum_pkg::*;

    logic                          lane_clear;
    logic [WORD_W-1:0]             word;
    logic [NUM_LANES-1:0]          word_strobe;
    logic [NUM_LANES*WORD_W-1:0]   lane_sums;
    logic                          flush;
    logic [WORD_W-1:0]             pseudo_sum;
    logic [15:0]                   udp_length;
    logic                          fold_idle;

    csum_word_packer u_packer (
        .clk           (clk),
        .reset         (reset),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .src_ip        (src_ip),
        .dst_ip        (dst_ip),
        .src_port      (src_port),
        .dst_port      (dst_port),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_ready (payload_ready),
        .fold_idle     (fold_idle),
        .lane_clear    (lane_clear),
        .word          (word),
        .word_strobe   (word_strobe),
        .flush         (flush),
        .pseudo_sum    (pseudo_sum),
        .udp_length    (udp_length),
        .busy          (busy)
    );

    // payload words are dealt round-robin across the lanes
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        csum_lane u_lane (
            .clk      (clk),
            .reset    (reset),
            .clear    (lane_clear),
            .strobe   (word_strobe[k]),
            .word     (word),
            .lane_sum (lane_sums[k*WORD_W +: WORD_W])
        );
    end

    csum_fold u_fold (
        .clk         (clk),
        .reset       (reset),
        .lane_sums   (lane_sums),
        .flush       (flush),
        .pseudo_sum  (pseudo_sum),
        .udp_length  (udp_length),
        .csum        (csum),
        .csum_length (csum_length),
        .csum_valid  (csum_valid),
        .csum_ready  (csum_ready),
        .fold_idle   (fold_idle)
    );

endmodule

// File: testbench/udp_csum_ref.svh
`ifndef UDP_CSUM_REF_SVH
`define UDP_CSUM_REF_SVH

localparam int MAX_TESTS   = 64;
localparam int MAX_PAYLOAD = 64;

string        t_name    [MAX_TESTS];
logic [31:0]  t_src_ip  [MAX_TESTS];
logic [31:0]  t_dst_ip  [MAX_TESTS];
logic [15:0]  t_src_prt [MAX_TESTS];
logic [15:0]  t_dst_prt [MAX_TESTS];
int           t_len     [MAX_TESTS];
bit           t_gap     [MAX_TESTS];
int           t_stall   [MAX_TESTS];
bit           t_force   [MAX_TESTS];
int           num_tests = 0;

// payload of the datagram being sent
logic [7:0]   payload_buf [MAX_PAYLOAD];

task automatic add_entry(input string name, input logic [31:0] sip, input logic [31:0] dip,
                         input logic [15:0] sprt, input logic [15:0] dprt, input int len,
                         input int gap, input int stall, input int force_ones);
    t_name[num_tests]    = name;
    t_src_ip[num_tests]  = sip;
    t_dst_ip[num_tests]  = dip;
    t_src_prt[num_tests] = sprt;
    t_dst_prt[num_tests] = dprt;
    t_len[num_tests]     = len;
    t_gap[num_tests]     = (gap != 0);
    t_stall[num_tests]   = stall;
    t_force[num_tests]   = (force_ones != 0);
    num_tests++;
endtask

// force entries need an even length so the last two bytes form one word
task automatic load_table();
    add_entry("single_a", 32'hc0a80001, 32'hc0a800c7, 16'd1234, 16'd53, 1, 0, 0, 0);
    add_entry("single_b", 32'hffffffff, 32'hffffffff, 16'hffff, 16'hffff, 1, 0, 0, 0);
    add_entry("single_c", 32'h00000000, 32'h00000000, 16'h0000, 16'h0000, 1, 0, 0, 0);
    for (int n = 1; n <= 40; n++) begin
        add_entry($sformatf("len_%0d", n), 32'h0a000000 + n, 32'h0a0000fe - n,
                  16'(1000 + n), 16'(4000 + 3 * n), n, 0, 0, 0);
    end
    add_entry("gap_odd", 32'hac100a01, 32'hac100a02, 16'd5000, 16'd5001, 17, 1, 0, 0);
    add_entry("gap_even", 32'h7f000001, 32'h7f000001, 16'd68, 16'd67, 32, 1, 0, 0);
    add_entry("stall_a", 32'h01020304, 32'h05060708, 16'd9, 16'd7, 6, 0, 5, 0);
    add_entry("stall_gap", 32'hdeadbeef, 32'h12345678, 16'd443, 16'd8443, 9, 1, 12, 0);
    add_entry("force_a", 32'hc0a80164, 32'hc0a801fe, 16'd123, 16'd321, 2, 0, 0, 1);
    add_entry("force_gap", 32'h08080808, 32'h08080404, 16'd53, 16'd40000, 20, 1, 0, 1);
    add_entry("force_stall", 32'h0a0a0a0a, 32'h0b0b0b0b, 16'd161, 16'd162, 12, 0, 3, 1);
endtask

function automatic logic [15:0] fold_carries(input logic [31:0] total);
    logic [31:0] s;
    s = total;
    while (s[31:16] != 16'd0) begin
        s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    end
    return s[15:0];
endfunction

// unfolded sum of the pseudo-header, the udp header and the first count payload bytes
function automatic logic [31:0] raw_total(input int idx, input int count);
    logic [31:0] s;
    logic [15:0] udp_len;
    logic [7:0]  lo;
    udp_len = 16'(t_len[idx] + 8);
    s = {16'd0, t_src_ip[idx][31:16]} + {16'd0, t_src_ip[idx][15:0]};
    s = s + {16'd0, t_dst_ip[idx][31:16]} + {16'd0, t_dst_ip[idx][15:0]};
    s = s + 32'h0000_0011 + {16'd0, udp_len};
    s = s + {16'd0, t_src_prt[idx]} + {16'd0, t_dst_prt[idx]} + {16'd0, udp_len};
    for (int i = 0; i < count; i += 2) begin
        lo = (i + 1 < count) ? payload_buf[i + 1] : 8'h00;
        s = s + {16'd0, payload_buf[i], lo};
    end
    return s;
endfunction

function automatic logic [15:0] expected_csum(input int idx);
    logic [15:0] c;
    c = ~fold_carries(raw_total(idx, t_len[idx]));
    return (c == 16'h0000) ? 16'hffff : c;
endfunction

`endif

// File: testbench/udp_csum_gen_tb.sv
`timescale 1ns/1ps

module udp_csum_gen_tb;

    import udp_csum_pkg::*;

    logic         clk;
    logic         reset;
    logic         hdr_valid;
    logic         hdr_ready;
    logic [31:0]  src_ip;
    logic [31:0]  dst_ip;
    logic [15:0]  src_port;
    logic [15:0]  dst_port;
    logic [7:0]   payload_data;
    logic         payload_valid;
    logic         payload_last;
    logic         payload_ready;
    logic [15:0]  csum;
    logic [15:0]  csum_length;
    logic         csum_valid;
    logic         csum_ready;
    logic         busy;

    int           cyc = 0;
    int           last_edge;
    int           test_errors;
    int           pass_count = 0;
    int           fail_count = 0;
    string        cur_name;
    bit           table_ready = 0;

    `include "udp_csum_ref.svh"

    udp_csum_gen u_dut (
        .clk           (clk),
        .reset         (reset),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .src_ip        (src_ip),
        .dst_ip        (dst_ip),
        .src_port      (src_port),
        .dst_port      (dst_port),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_ready (payload_ready),
        .csum          (csum),
        .csum_length   (csum_length),
        .csum_valid    (csum_valid),
        .csum_ready    (csum_ready),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // rising edges counted for the latency check
    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", cur_name);
        end else begin
            fail_count++;
            $display("FAIL %s (%0d errors)", cur_name, test_errors);
        end
    endtask

    task automatic fill_payload(input int idx);
        int          n;
        logic [15:0] part;
        n = t_len[idx];
        for (int i = 0; i < n; i++) begin
            payload_buf[i] = 8'($urandom);
        end
        // last word cancels the rest so the total sum is all ones
        if (t_force[idx]) begin
            part = fold_carries(raw_total(idx, n - 2));
            payload_buf[n - 2] = ~part[15:8];
            payload_buf[n - 1] = ~part[7:0];
        end
    endtask

    task automatic send_header(input int idx);
        @(posedge clk);
        #1;
        src_ip    = t_src_ip[idx];
        dst_ip    = t_dst_ip[idx];
        src_port  = t_src_prt[idx];
        dst_port  = t_dst_prt[idx];
        hdr_valid = 1'b1;
        @(negedge clk);
        while (!hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input int idx);
        int n;
        int idle;
        n = t_len[idx];
        for (int i = 0; i < n; i++) begin
            if (t_gap[idx]) begin
                idle = $urandom % 3;
                payload_valid = 1'b0;
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                end
            end
            payload_valid = 1'b1;
            payload_data  = payload_buf[i];
            payload_last  = (i == n - 1);
            @(negedge clk);
            while (!payload_ready) @(negedge clk);
            if (i == n - 1) begin
                last_edge = cyc + 1;
            end
            @(posedge clk);
            #1;
        end
        payload_valid = 1'b0;
        payload_last  = 1'b0;
    endtask

    task automatic run_test(input int idx);
        logic [15:0] exp_csum;
        logic [15:0] held;
        test_errors = 0;
        cur_name    = t_name[idx];
        fill_payload(idx);
        exp_csum = expected_csum(idx);
        send_header(idx);
        send_payload(idx);
        csum_ready = (t_stall[idx] == 0);
        @(negedge clk);
        while (!csum_valid) @(negedge clk);
        check_equal("latency", NUM_LANES + 4, cyc - last_edge);
        check_equal("busy", 1, busy);
        check_equal("csum", exp_csum, csum);
        check_equal("length", t_len[idx] + 8, csum_length);
        if (t_force[idx]) begin
            check_equal("forced csum", 16'hffff, csum);
        end
        held = csum;
        if (t_stall[idx] > 0) begin
            repeat (t_stall[idx]) begin
                @(negedge clk);
                check_equal("held csum", held, csum);
                check_equal("held length", t_len[idx] + 8, csum_length);
                check_equal("held valid", 1, csum_valid);
                check_equal("hdr_ready in stall", 0, hdr_ready);
            end
            @(posedge clk);
            #1;
            csum_ready = 1'b1;
        end
        @(posedge clk);
        #1;
        csum_ready = 1'b0;
        @(negedge clk);
        check_equal("busy after take", 0, busy);
        check_equal("valid after take", 0, csum_valid);
        report_test();
    endtask

    initial begin
        void'($urandom(32'h4692aad9));
        reset         = 1'b1;
        hdr_valid     = 1'b0;
        src_ip        = '0;
        dst_ip        = '0;
        src_port      = '0;
        dst_port      = '0;
        payload_data  = '0;
        payload_valid = 1'b0;
        payload_last  = 1'b0;
        csum_ready    = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        test_errors = 0;
        cur_name    = "after_reset";
        check_equal("csum_valid", 0, csum_valid);
        check_equal("payload_ready", 0, payload_ready);
        check_equal("busy", 0, busy);
        check_equal("hdr_ready", 1, hdr_ready);
        report_test();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // gaps add at most two idle cycles per byte
    initial begin
        int limit;
        wait (table_ready);
        limit = 40;
        for (int t = 0; t < num_tests; t++) begin
            limit += 3 * t_len[t] + t_stall[t] + 30;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
hw/udp_csum_pkg.sv
hw/csum_word_packer.sv
hw/csum_lane.sv
hw/csum_fold.sv
hw/udp_csum_gen.sv
testbench/udp_csum_gen_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := udp_csum_gen_tb
FILELIST := verilog.f
BUILD    := obj_dir

BIN      := $(BUILD)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard testbench/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD)
